/* hdl/ctrace_defs.svh */
`ifndef CTRACE_DEFS_SVH
`define CTRACE_DEFS_SVH

// word format is signed Q16.16
`define CT_DATA_W 32
`define CT_FRAC_W 16 // fractional bits of a word

// camera coordinates
`define CT_ROW_W 12
`define CT_COL_W 12

// taps per footprint row and number of footprint rows
`define CT_N_FSP 3

// pipeline depth of the arithmetic units in cycles
`define CT_MULT_LAT 3
`define CT_ADD_LAT 2

`endif

/* hdl/ctrace_geom_pkg.sv */
`include "ctrace_defs.svh"

package ct_geom_pkg;

  // camera position of a pixel or a trace sample
  typedef struct packed {
    logic [`CT_ROW_W-1:0] row;
    logic [`CT_COL_W-1:0] col;
  } ct_pos_t;

  // per-pixel configuration loaded with init
  typedef struct packed {
    ct_pos_t                      pos;           // pixel being projected
    logic signed [`CT_DATA_W-1:0] initial_value; // Q16.16 start of the sum
  } ct_cfg_t;

endpackage

/* hdl/ctrace_data_pkg.sv */
`include "ctrace_defs.svh"

package ct_data_pkg;

  // signed Q16.16 data word
  typedef logic signed [`CT_DATA_W-1:0] ct_word_t;

  // one trace sample off the camera stream
  typedef struct packed {
    ct_geom_pkg::ct_pos_t pos;
    ct_word_t             value;
  } ct_sample_t;

  // taps of one footprint row, index is the column offset
  typedef ct_word_t [`CT_N_FSP-1:0] fsp_row_t;

  // whole footprint, one entry per footprint row
  typedef fsp_row_t [`CT_N_FSP-1:0] fsp_set_t;

  // one projection result per footprint row
  typedef ct_word_t [`CT_N_FSP-1:0] ct_result_t;

endpackage

/* hdl/fx_mult.sv */
`timescale 1ns/1ps
`include "ctrace_defs.svh"

module fx_mult #(
  parameter int LANES = 1 // operand pairs handled in parallel
) (
  input  logic                               CLK,
  input  logic                               RESET,
  input  logic                               nd,
  input  ct_data_pkg::ct_word_t [LANES-1:0]  a,
  input  ct_data_pkg::ct_word_t [LANES-1:0]  b,
  output ct_data_pkg::ct_word_t [LANES-1:0]  result,
  output logic                               rdy
);

  ct_data_pkg::ct_word_t [LANES-1:0]  a_q;
  ct_data_pkg::ct_word_t [LANES-1:0]  b_q;
  logic signed [2*`CT_DATA_W-1:0]     prod_q [LANES]; // full 64-bit product
  logic [`CT_MULT_LAT-1:0]            vld;            // one bit per stage

  always_ff @(posedge CLK) begin
    if (RESET) begin
      vld <= '0;
    end else begin
      vld <= {vld[`CT_MULT_LAT-2:0], nd};
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < LANES; i++) begin
      a_q[i]    <= a[i];             // stage 1
      b_q[i]    <= b[i];
      prod_q[i] <= a_q[i] * b_q[i];  // stage 2 signed product
      // stage 3 drops the low fraction bits and keeps 32 bits
      result[i] <= prod_q[i][`CT_DATA_W+`CT_FRAC_W-1:`CT_FRAC_W];
    end
  end

  assign rdy = vld[`CT_MULT_LAT-1];

endmodule

/* hdl/fx_add.sv */
`timescale 1ns/1ps
`include "ctrace_defs.svh"

module fx_add (
  input  logic                  CLK,
  input  logic                  RESET,
  input  logic                  nd,
  input  ct_data_pkg::ct_word_t a,
  input  ct_data_pkg::ct_word_t b,
  output ct_data_pkg::ct_word_t result,
  output logic                  rdy
);

  ct_data_pkg::ct_word_t  a_q;
  ct_data_pkg::ct_word_t  b_q;
  logic [`CT_ADD_LAT-1:0] vld; // travels with the operands

  always_ff @(posedge CLK) begin
    if (RESET) begin
      vld <= '0;
    end else begin
      vld <= {vld[`CT_ADD_LAT-2:0], nd};
    end
  end

  always_ff @(posedge CLK) begin
    a_q    <= a;
    b_q    <= b;
    result <= a_q + b_q; // wraps modulo 2^32
  end

  assign rdy = vld[`CT_ADD_LAT-1];

endmodule

/* hdl/row_summer.sv */
`timescale 1ns/1ps
`include "ctrace_defs.svh"

module row_summer #(
  parameter int FSP_ROW = 0 // footprint row handled by this summer
) (
  input  logic                    CLK,
  input  logic                    RESET,
  input  logic                    init,
  input  ct_geom_pkg::ct_cfg_t    cfg,
  input  logic                    sample_valid,
  input  ct_data_pkg::ct_sample_t sample,
  input  ct_data_pkg::fsp_row_t   fsp,
  input  logic                    ack,
  output logic                    available,
  output logic                    done,
  output ct_data_pkg::ct_word_t   result
);

  localparam int CNT_W = $clog2(`CT_N_FSP);

  typedef enum logic [2:0] {
    ST_ERROR,
    ST_FREE,
    ST_COLLECT,
    ST_FINISH,
    ST_DONE
  } state_t;

  state_t                       state;
  logic [CNT_W-1:0]             n_recv;       // taps captured so far
  logic                         start_calc;
  ct_geom_pkg::ct_cfg_t         cfg_q;

  // sample delayed by one cycle
  logic                         sample_valid_d;
  ct_data_pkg::ct_word_t        sample_val_d;
  ct_data_pkg::fsp_row_t        fsp_d;
  logic [`CT_ROW_W-1:0]         eff_row_d;    // sample row plus FSP_ROW
  logic signed [`CT_COL_W:0]    col_off_d;    // pixel col minus sample col

  logic                         is_before;
  logic                         is_overlap;

  // captured operands, unused slots stay zero
  ct_data_pkg::fsp_row_t        val_slot;
  ct_data_pkg::fsp_row_t        tap_slot;

  wire ct_data_pkg::fsp_row_t   prod;
  logic                         prod01_rdy;
  logic                         prod2_rdy;
  ct_data_pkg::ct_word_t        psum0;
  ct_data_pkg::ct_word_t        psum1;
  logic                         psum0_rdy;
  ct_data_pkg::ct_word_t        sum;
  logic                         sum_rdy;

  assign available = (state == ST_FREE);
  assign done      = (state == ST_DONE);

  always_ff @(posedge CLK) begin
    sample_val_d <= sample.value;
    fsp_d        <= fsp;
    eff_row_d    <= sample.pos.row + `CT_ROW_W'(FSP_ROW);
    col_off_d    <= $signed({1'b0, cfg_q.pos.col}) - $signed({1'b0, sample.pos.col});
  end

  assign is_before  = (eff_row_d > cfg_q.pos.row) ||
                      (eff_row_d == cfg_q.pos.row && col_off_d < 0);
  assign is_overlap = (eff_row_d == cfg_q.pos.row) &&
                      (col_off_d >= 0) && (col_off_d < `CT_N_FSP);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state          <= ST_FREE;
      n_recv         <= '0;
      start_calc     <= 1'b0;
      sample_valid_d <= 1'b0;
    end else begin
      start_calc     <= 1'b0;              // single-cycle pulse
      sample_valid_d <= sample_valid;
      case (state)
        ST_FREE: begin
          if (init) begin
            cfg_q    <= cfg;
            val_slot <= '0;
            tap_slot <= '0;
            n_recv   <= '0;
            state    <= ST_COLLECT;
          end
        end
        ST_COLLECT: begin
          if (sample_valid_d && !is_before) begin
            if (is_overlap) begin
              val_slot[n_recv] <= sample_val_d;
              tap_slot[n_recv] <= fsp_d[col_off_d[CNT_W-1:0]];
              n_recv           <= n_recv + 1'b1;
              if (n_recv == CNT_W'(`CT_N_FSP-1)) begin // slots full
                n_recv     <= '0;
                start_calc <= 1'b1;
                state      <= ST_FINISH;
              end
            end else begin                 // sample is past the footprint
              n_recv <= '0;
              if (n_recv != '0) begin
                start_calc <= 1'b1;
                state      <= ST_FINISH;
              end else begin
                result <= cfg_q.initial_value; // nothing overlapped
                state  <= ST_DONE;
              end
            end
          end
        end
        ST_FINISH: begin
          if (sum_rdy) begin
            result   <= sum;
            val_slot <= '0;
            tap_slot <= '0;
            state    <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (ack) begin
            state <= ST_FREE;
          end
        end
        ST_ERROR: begin
          state <= ST_ERROR; // no way out
        end
        default: begin
          state <= ST_ERROR;
        end
      endcase
    end
  end

  // products 0 and 1 share one unit, product 2 has its own
  fx_mult #(.LANES(2)) mult01_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .nd     (start_calc),
    .a      (val_slot[1:0]),
    .b      (tap_slot[1:0]),
    .result (prod[1:0]),
    .rdy    (prod01_rdy)
  );

  fx_mult #(.LANES(1)) mult2_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .nd     (start_calc),
    .a      (val_slot[2:2]),
    .b      (tap_slot[2:2]),
    .result (prod[2:2]),
    .rdy    (prod2_rdy)
  );

  // adder tree is laid out for three taps
  fx_add add0_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .nd     (prod01_rdy),
    .a      (cfg_q.initial_value),
    .b      (prod[0]),
    .result (psum0),
    .rdy    (psum0_rdy)
  );

  fx_add add1_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .nd     (prod2_rdy),
    .a      (prod[1]),
    .b      (prod[2]),
    .result (psum1),
    .rdy    ()                  // same timing as psum0_rdy
  );

  fx_add add_final_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .nd     (psum0_rdy),
    .a      (psum0),
    .b      (psum1),
    .result (sum),
    .rdy    (sum_rdy)
  );

endmodule

/* hdl/ctrace_projector_top.sv */
`timescale 1ns/1ps
`include "ctrace_defs.svh"

module ctrace_projector_top (
  input  logic                      CLK,
  input  logic                      RESET,
  input  logic                      init,
  input  ct_geom_pkg::ct_cfg_t      cfg,
  input  logic                      sample_valid,
  input  ct_data_pkg::ct_sample_t   sample,
  input  ct_data_pkg::fsp_set_t     fsp,
  input  logic [`CT_N_FSP-1:0]      ack,
  output wire [`CT_N_FSP-1:0]       available,
  output wire [`CT_N_FSP-1:0]       done,
  output wire ct_data_pkg::ct_result_t result
);

  genvar r;

  // one summer per footprint row, all watching the same stream
  generate
    for (r = 0; r < `CT_N_FSP; r++) begin : g_row
      row_summer #(
        .FSP_ROW (r)
      ) row_summer_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .init         (init),
        .cfg          (cfg),
        .sample_valid (sample_valid),
        .sample       (sample),
        .fsp          (fsp[r]),       // taps of footprint row r
        .ack          (ack[r]),
        .available    (available[r]),
        .done         (done[r]),
        .result       (result[r])
      );
    end
  endgenerate

endmodule

/* verification/ctrace_projector_sva.sv */
`timescale 1ns/1ps

module ctrace_projector_sva (
  input logic CLK,
  input logic RESET,
  input logic ack,
  input logic available,
  input logic done
);

  int fail_count = 0; // summed by the testbench at the end of the run

  // a summer is never free and finished at once
  a_not_both: assert property (@(posedge CLK) disable iff (RESET) !(available && done))
    else begin
      fail_count++;
      $error("available and done high in the same cycle");
    end

  a_done_held: assert property (@(posedge CLK) disable iff (RESET) done && !ack |=> done)
    else begin
      fail_count++;
      $error("done dropped before ack");
    end

  a_reset_state: assert property (@(posedge CLK) RESET |=> available && !done)
    else begin
      fail_count++;
      $error("summer not free after reset");
    end

endmodule

bind row_summer ctrace_projector_sva sva_i (
  .CLK       (CLK),
  .RESET     (RESET),
  .ack       (ack),
  .available (available),
  .done      (done)
);

/* verification/ctrace_projector_tb.sv */
`timescale 1ns/1ps
`include "ctrace_defs.svh"

module ctrace_projector_tb;

  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES  = 10;
  localparam int N_TESTS      = 8;
  localparam int MAX_SAMPLES  = 64;  // longest stream of any test
  localparam int MAX_HOLD     = 40;  // longest ack delay
  localparam int TEST_CYCLES  = 2 * MAX_SAMPLES + MAX_HOLD + 32;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES + N_TESTS * TEST_CYCLES + 100;

  logic                      CLK;
  logic                      RESET;
  logic                      init;
  ct_geom_pkg::ct_cfg_t      cfg;
  logic                      sample_valid;
  ct_data_pkg::ct_sample_t   sample;
  ct_data_pkg::fsp_set_t     fsp;
  logic [`CT_N_FSP-1:0]      ack;
  wire  [`CT_N_FSP-1:0]      available;
  wire  [`CT_N_FSP-1:0]      done;
  wire ct_data_pkg::ct_result_t result;

  ct_data_pkg::ct_sample_t   stim_smp [$];
  ct_data_pkg::fsp_set_t     stim_fsp [$];
  ct_data_pkg::ct_word_t     exp_result [`CT_N_FSP];
  int                        hold_len [`CT_N_FSP];
  logic                      test_active;
  int                        rows_finished;
  int                        error_count;
  int                        tests_passed;
  int                        tests_failed;
  int                        cycle_count;

  ctrace_projector_top ctrace_projector_top_i (
    .CLK          (CLK),
    .RESET        (RESET),
    .init         (init),
    .cfg          (cfg),
    .sample_valid (sample_valid),
    .sample       (sample),
    .fsp          (fsp),
    .ack          (ack),
    .available    (available),
    .done         (done),
    .result       (result)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic check_word(input string name, input ct_data_pkg::ct_word_t got,
                            input ct_data_pkg::ct_word_t exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input logic [`CT_N_FSP-1:0] got,
                             input logic [`CT_N_FSP-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR %s got 0x%01h expected 0x%01h", name, got, exp);
    end
  endtask

  function automatic ct_data_pkg::ct_word_t rand_value();
    ct_data_pkg::ct_word_t w;
    w = $urandom;
    return w >>> 12; // within +-8.0
  endfunction

  function automatic ct_data_pkg::fsp_set_t rand_fsp();
    ct_data_pkg::fsp_set_t f;
    ct_data_pkg::ct_word_t w;
    for (int i = 0; i < `CT_N_FSP; i++) begin
      for (int j = 0; j < `CT_N_FSP; j++) begin
        w = $urandom;
        f[i][j] = w >>> 15; // taps within +-1.0
      end
    end
    return f;
  endfunction

  // expected result of one footprint row and whether the stream closes it
  function automatic bit ref_row_result(
    input  ct_geom_pkg::ct_cfg_t    c,
    input  ct_data_pkg::ct_sample_t smp [$],
    input  ct_data_pkg::fsp_set_t   fsps [$],
    input  int                      row_off,
    output ct_data_pkg::ct_word_t   res
  );
    int                 eff_row;
    int                 off;
    int                 taps;
    logic signed [63:0] val64;
    logic signed [63:0] tap64;
    res  = c.initial_value;
    taps = 0;
    for (int i = 0; i < smp.size(); i++) begin
      eff_row = int'(smp[i].pos.row) + row_off;
      off     = int'(c.pos.col) - int'(smp[i].pos.col);
      if (eff_row > int'(c.pos.row) || (eff_row == int'(c.pos.row) && off < 0)) begin
        continue; // still ahead of the footprint
      end
      if (eff_row != int'(c.pos.row) || off >= `CT_N_FSP) begin
        return 1'b1; // past the footprint
      end
      val64 = $signed(smp[i].value);
      tap64 = $signed(fsps[i][row_off][off]);
      res   = res + ct_data_pkg::ct_word_t'((val64 * tap64) >>> 16);
      taps++;
      if (taps == `CT_N_FSP) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic add_sample(input int row, input int col);
    ct_data_pkg::ct_sample_t s;
    s.pos.row = `CT_ROW_W'(row);
    s.pos.col = `CT_COL_W'(col);
    s.value   = rand_value();
    stim_smp.push_back(s);
    stim_fsp.push_back(rand_fsp());
  endtask

  // camera raster runs with falling rows and columns
  task automatic add_raster(input int row_hi, input int row_lo, input int col_hi, input int col_lo);
    for (int row = row_hi; row >= row_lo; row--) begin
      for (int col = col_hi; col >= col_lo; col--) begin
        add_sample(row, col);
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic idle_check();
    int errors_before;
    errors_before = error_count;
    repeat (IDLE_CYCLES) begin
      sample_valid   = 1'($urandom_range(1, 0)); // free summers ignore the stream
      sample.pos.row = `CT_ROW_W'($urandom);
      sample.pos.col = `CT_COL_W'($urandom);
      sample.value   = rand_value();
      fsp            = rand_fsp();
      @(negedge CLK);
      check_flags("available", available, 3'b111);
      check_flags("done", done, 3'b000);
    end
    sample_valid = 1'b0;
    report_test("reset_state", errors_before);
  endtask

  task automatic run_test(input string name, input int pix_row, input int pix_col,
                          input int hold_max);
    ct_geom_pkg::ct_cfg_t c;
    int                   errors_before;
    int                   target;
    errors_before   = error_count;
    c.pos.row       = `CT_ROW_W'(pix_row);
    c.pos.col       = `CT_COL_W'(pix_col);
    c.initial_value = rand_value();
    add_sample(0, 0); // behind every footprint row
    for (int r = 0; r < `CT_N_FSP; r++) begin
      if (!ref_row_result(c, stim_smp, stim_fsp, r, exp_result[r])) begin
        error_count++;
        $display("stream of test %s never closes footprint row %0d", name, r);
      end
      hold_len[r] = $urandom_range(hold_max, 0);
    end
    check_flags("available", available, 3'b111);
    check_flags("done", done, 3'b000);
    target       = rows_finished + `CT_N_FSP;
    test_active  = 1'b1;
    sample_valid = 1'b0;
    init         = 1'b1;
    cfg          = c;
    @(negedge CLK);
    init = 1'b0;
    foreach (stim_smp[i]) begin
      if ($urandom_range(3, 0) == 0) begin
        sample_valid = 1'b0; // gap in the stream
        @(negedge CLK);
      end
      sample_valid = 1'b1;
      sample       = stim_smp[i];
      fsp          = stim_fsp[i];
      @(negedge CLK);
    end
    // samples over the pixel's own taps until every row is acked
    while (rows_finished < target) begin
      sample_valid   = 1'($urandom_range(1, 0));
      sample.pos.row = `CT_ROW_W'(pix_row - int'($urandom_range(2, 0)));
      sample.pos.col = `CT_COL_W'(pix_col - int'($urandom_range(2, 0)));
      sample.value   = rand_value();
      fsp            = rand_fsp();
      @(negedge CLK);
    end
    sample_valid = 1'b0;
    test_active  = 1'b0;
    report_test(name, errors_before);
    stim_smp.delete();
    stim_fsp.delete();
  endtask

  function automatic int sva_failures();
    return ctrace_projector_top_i.g_row[0].row_summer_i.sva_i.fail_count +
           ctrace_projector_top_i.g_row[1].row_summer_i.sva_i.fail_count +
           ctrace_projector_top_i.g_row[2].row_summer_i.sva_i.fail_count;
  endfunction

  initial begin : compare_results
    int                   phase [`CT_N_FSP];
    int                   hold_left [`CT_N_FSP];
    int                   finished;
    logic [`CT_N_FSP-1:0] mask;
    ack           = '0;
    rows_finished = 0;
    finished      = 0;
    for (int r = 0; r < `CT_N_FSP; r++) begin
      phase[r]     = 0;
      hold_left[r] = 0;
    end
    forever begin
      @(negedge CLK);
      for (int r = 0; r < `CT_N_FSP; r++) begin
        mask = `CT_N_FSP'(1) << r;
        case (phase[r])
          0: begin
            if (done[r] === 1'b1) begin
              if (!test_active) begin
                error_count++;
                $display("done[%0d] rose without an init", r);
              end
              check_word($sformatf("result[%0d]", r), result[r], exp_result[r]);
              hold_left[r] = hold_len[r];
              phase[r]     = 1;
            end
          end
          1: begin // result must stay put while ack is withheld
            check_flags($sformatf("done[%0d]", r), done & mask, mask);
            check_word($sformatf("result[%0d]", r), result[r], exp_result[r]);
            if (hold_left[r] == 0) begin
              ack[r]   <= 1'b1;
              phase[r] = 2;
            end else begin
              hold_left[r]--;
            end
          end
          default: begin
            ack[r] <= 1'b0;
            check_flags($sformatf("available[%0d]", r), available & mask, mask);
            check_flags($sformatf("done[%0d]", r), done & mask, 3'b000);
            finished++;
            phase[r] = 0;
          end
        endcase
      end
      rows_finished <= finished;
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count <= CYCLE_LIMIT) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout after %0d cycles with tests still running", cycle_count);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int row;
    int col;
    void'($urandom(32'hb82622a8));
    RESET        = 1'b1;
    init         = 1'b0;
    cfg          = '0;
    sample_valid = 1'b0;
    sample       = '0;
    fsp          = '0;
    test_active  = 1'b0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RESET = 1'b0;
    idle_check();
    add_raster(22, 17, 33, 26);
    run_test("full_overlap", 20, 30, 3);
    add_raster(12, 7, 5, 0);
    run_test("edge_col1", 10, 1, 3);
    add_raster(12, 7, 5, 0);
    run_test("edge_col0", 10, 0, 3);
    add_raster(58, 55, 44, 38);
    add_raster(47, 45, 44, 38); // jumps over rows 54 to 48
    run_test("no_overlap", 50, 40, 3);
    repeat (2) begin
      row = $urandom_range(40, 10);
      col = $urandom_range(40, 3);
      add_raster(row + 1, row - 3, col + 2, col - 3);
      run_test("backpressure", row, col, MAX_HOLD);
    end
    add_raster(29, 29, 22, 17);
    run_test("fsp_row1_only", 30, 20, 3);
    add_raster(28, 28, 22, 17);
    run_test("fsp_row2_only", 30, 20, 3);
    $display("tests passed %0d, failed %0d, assertion failures %0d",
             tests_passed, tests_failed, sva_failures());
    if (tests_failed == 0 && error_count == 0 && sva_failures() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/ctrace_geom_pkg.sv
hdl/ctrace_data_pkg.sv
hdl/fx_mult.sv
hdl/fx_add.sv
hdl/row_summer.sv
hdl/ctrace_projector_top.sv
verification/ctrace_projector_sva.sv
verification/ctrace_projector_tb.sv
